//--- run_sim.sh
#!/bin/sh
# compile and run the vmm testbench with Verilator, then look for the pass line
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module vmm_tb \
	-f vmatmul.f -o vmm_sim &&
./obj_dir/vmm_sim +verilator+error+limit+1000 > sim.log 2>&1
grep -qx "Done: no errors" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

//--- source/mac_lane.sv
// signed multiply-accumulate lane
`timescale 1ns/1ps
`default_nettype none

module mac_lane (
	input wire logic clk,
	input wire logic resetn,
	input vmm_pkg::lane_in_s lane_in,
	output logic signed [vmm_pkg::ACC_WIDTH-1:0] acc
);

	logic signed [2*vmm_pkg::ELEM_WIDTH-1:0] prod;

	// signed byte times signed byte
	assign prod = $signed(lane_in.a_elem) * $signed(lane_in.b_elem);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			acc <= '0;
		end else if (lane_in.clear) begin
			// clear wins over valid
			acc <= '0;
		end else if (lane_in.valid) begin
			// product sign-extends into acc, wraps on overflow
			acc <= acc + prod;
		end
	end

endmodule

`default_nettype wire

//--- source/operand_feeder.sv
// operand pair feeder
`timescale 1ns/1ps
`default_nettype none

module operand_feeder (
	input wire logic clk,
	input wire logic resetn,
	input wire logic a_we,
	input wire logic b_we,
	input vmm_pkg::vmm_word_u op_word,
	input wire logic vl_load,
	input vmm_pkg::ctrl_regs_s ctrl,
	output vmm_pkg::lane_in_s [vmm_pkg::MAT_MUL_SIZE-1:0] lanes,
	output logic [vmm_pkg::DATA_WIDTH-1:0] count
);

	logic take_pair;
	logic [vmm_pkg::MAT_MUL_SIZE-1:0] valid_q;
	logic clear_q;
	vmm_pkg::vmm_word_u a_hold;
	vmm_pkg::vmm_word_u a_pair;
	vmm_pkg::vmm_word_u b_pair;

	// b write closes a pair, dropped once vl pairs are in
	assign take_pair = b_we & (count < ctrl.vl);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= '0;
			valid_q <= '0;
			clear_q <= 1'b0;
		end else begin
			clear_q <= vl_load;
			valid_q <= '0;
			if (vl_load) begin
				count <= '0;
			end else if (take_pair) begin
				// only a_rows lanes accumulate
				valid_q <= ctrl.a_rows;
				count <= count + 1'b1;
			end
		end
	end

	// a waits here for its b
	always_ff @(posedge clk) begin
		if (a_we) begin
			a_hold <= op_word;
		end
		if (take_pair) begin
			a_pair <= a_hold;
			b_pair <= op_word;
		end
	end

	// element i of each word goes to lane i
	always_comb begin
		for (int i = 0; i < vmm_pkg::MAT_MUL_SIZE; i++) begin
			lanes[i].valid = valid_q[i];
			lanes[i].clear = clear_q;
			lanes[i].a_elem = a_pair.elems[i];
			lanes[i].b_elem = b_pair.elems[i];
		end
	end

endmodule

`default_nettype wire

//--- source/result_collector.sv
// masked lane sum and done flag
`timescale 1ns/1ps
`default_nettype none

module result_collector (
	input wire logic clk,
	input wire logic resetn,
	input wire logic [vmm_pkg::MAT_MUL_SIZE-1:0][vmm_pkg::ACC_WIDTH-1:0] accs,
	input vmm_pkg::ctrl_regs_s ctrl,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] count,
	input wire logic vl_load,
	output logic [vmm_pkg::DATA_WIDTH-1:0] result,
	output logic [vmm_pkg::DATA_WIDTH-1:0] status
);

	logic signed [vmm_pkg::DATA_WIDTH-1:0] sum;
	logic full;
	logic full_d;
	logic clr_d;
	logic done_q;

	// b_cols lanes only, sign-extended
	always_comb begin
		sum = '0;
		for (int i = 0; i < vmm_pkg::MAT_MUL_SIZE; i++) begin
			if (ctrl.b_cols[i]) begin
				sum = sum + $signed(accs[i]);
			end
		end
	end

	// last pair taken
	assign full = (count == ctrl.vl) && (ctrl.vl != '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			result <= '0;
			full_d <= 1'b0;
			clr_d <= 1'b0;
			done_q <= 1'b0;
		end else begin
			clr_d <= vl_load;
			if (vl_load || clr_d) begin
				// hold zero until lanes have cleared
				result <= '0;
				full_d <= 1'b0;
				done_q <= 1'b0;
			end else begin
				result <= sum;
				// one cycle for the lanes, one for the sum
				full_d <= full;
				done_q <= full_d;
			end
		end
	end

	// done in bit 0, pair count in 15:8
	always_comb begin
		status = '0;
		status[0] = done_q;
		status[15:8] = count[7:0];
	end

endmodule

`default_nettype wire

//--- source/vmm_pkg.sv
// vector matmul shared definitions
`default_nettype none

package vmm_pkg;

	// sizes
	localparam int MAT_MUL_SIZE = 4;
	localparam int DATA_WIDTH = 32;
	localparam int NUM_REGS = 32;
	localparam int LOG2_NUM_REGS = 5;
	localparam int ELEM_WIDTH = 8;
	localparam int ACC_WIDTH = 24;
	// register index plus the engine select bit
	localparam int ADR_WIDTH = LOG2_NUM_REGS + 1;

	// control register indices
	localparam logic [LOG2_NUM_REGS-1:0] REG_VL = 5'd0;
	localparam logic [LOG2_NUM_REGS-1:0] REG_B_COLS = 5'd29;
	localparam logic [LOG2_NUM_REGS-1:0] REG_A_COLS = 5'd30;
	localparam logic [LOG2_NUM_REGS-1:0] REG_A_ROWS = 5'd31;

	// engine offsets, used when adr[5] is set
	localparam logic [1:0] ENG_A = 2'd0;
	localparam logic [1:0] ENG_B = 2'd1;
	localparam logic [1:0] ENG_RESULT = 2'd2;
	localparam logic [1:0] ENG_STATUS = 2'd3;

	typedef logic signed [ELEM_WIDTH-1:0] elem_t;

	// mask sits in the low bits of a register word
	typedef struct packed {
		logic [DATA_WIDTH-MAT_MUL_SIZE-1:0] pad;
		logic [MAT_MUL_SIZE-1:0] mask;
	} mask_field_s;

	// one bus word, read as lane elements or as a mask
	typedef union packed {
		elem_t [MAT_MUL_SIZE-1:0] elems;
		mask_field_s mask_field;
	} vmm_word_u;

	typedef struct packed {
		logic en;
		logic [LOG2_NUM_REGS-1:0] idx;
		vmm_word_u data;
	} regfile_wr_s;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] vl;
		logic [MAT_MUL_SIZE-1:0] a_rows;
		logic [MAT_MUL_SIZE-1:0] a_cols;
		logic [MAT_MUL_SIZE-1:0] b_cols;
	} ctrl_regs_s;

	typedef struct packed {
		logic valid;
		logic clear;
		elem_t a_elem;
		elem_t b_elem;
	} lane_in_s;

endpackage

`default_nettype wire

//--- source/vmm_top.sv
// vector matmul control top
`timescale 1ns/1ps
`default_nettype none

module vmm_top (
	input wire logic clk,
	input wire logic resetn,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [vmm_pkg::ADR_WIDTH-1:0] adr,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] dat_w,
	output logic [vmm_pkg::DATA_WIDTH-1:0] dat_r,
	output logic ack
);

	vmm_pkg::regfile_wr_s reg_wr;
	logic reg_rd_en;
	logic [vmm_pkg::LOG2_NUM_REGS-1:0] reg_rd_reg;
	logic [vmm_pkg::DATA_WIDTH-1:0] reg_rd_data;
	vmm_pkg::ctrl_regs_s ctrl;
	logic a_we;
	logic b_we;
	logic vl_load;
	vmm_pkg::vmm_word_u op_word;
	vmm_pkg::lane_in_s [vmm_pkg::MAT_MUL_SIZE-1:0] lanes;
	logic [vmm_pkg::MAT_MUL_SIZE-1:0][vmm_pkg::ACC_WIDTH-1:0] accs;
	logic [vmm_pkg::DATA_WIDTH-1:0] count;
	logic [vmm_pkg::DATA_WIDTH-1:0] result;
	logic [vmm_pkg::DATA_WIDTH-1:0] status;

	// host side
	wb_slave_port wb_slave_port_i (
		.clk(clk),
		.resetn(resetn),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.reg_rd_data(reg_rd_data),
		.result(result),
		.status(status),
		.ack(ack),
		.dat_r(dat_r),
		.reg_wr(reg_wr),
		.reg_rd_en(reg_rd_en),
		.reg_rd_reg(reg_rd_reg),
		.a_we(a_we),
		.b_we(b_we),
		.op_word(op_word),
		.vl_load(vl_load)
	);

	vregfile_control vregfile_control_i (
		.clk(clk),
		.resetn(resetn),
		.rd_en(reg_rd_en),
		.rd_reg(reg_rd_reg),
		.wr(reg_wr),
		.rd_data(reg_rd_data),
		.ctrl(ctrl)
	);

	operand_feeder operand_feeder_i (
		.clk(clk),
		.resetn(resetn),
		.a_we(a_we),
		.b_we(b_we),
		.op_word(op_word),
		.vl_load(vl_load),
		.ctrl(ctrl),
		.lanes(lanes),
		.count(count)
	);

	// one lane per mask bit
	for (genvar i = 0; i < vmm_pkg::MAT_MUL_SIZE; i++) begin : g_lane
		mac_lane mac_lane_i (
			.clk(clk),
			.resetn(resetn),
			.lane_in(lanes[i]),
			.acc(accs[i])
		);
	end

	result_collector result_collector_i (
		.clk(clk),
		.resetn(resetn),
		.accs(accs),
		.ctrl(ctrl),
		.count(count),
		.vl_load(vl_load),
		.result(result),
		.status(status)
	);

endmodule

`default_nettype wire

//--- source/vregfile_control.sv
// control register file
`timescale 1ns/1ps
`default_nettype none

module vregfile_control (
	input wire logic clk,
	input wire logic resetn,
	input wire logic rd_en,
	input wire logic [vmm_pkg::LOG2_NUM_REGS-1:0] rd_reg,
	input vmm_pkg::regfile_wr_s wr,
	output logic [vmm_pkg::DATA_WIDTH-1:0] rd_data,
	output vmm_pkg::ctrl_regs_s ctrl
);

	// general storage, inferred
	logic [vmm_pkg::DATA_WIDTH-1:0] mem [vmm_pkg::NUM_REGS];

	// mask zero-extended into a full word
	function automatic vmm_pkg::vmm_word_u mask_word(
		input logic [vmm_pkg::MAT_MUL_SIZE-1:0] m
	);
		vmm_pkg::vmm_word_u w;
		w.mask_field.pad = '0;
		w.mask_field.mask = m;
		return w;
	endfunction

	// write port, plus registered read
	// read sees old data on a same-cycle write
	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.idx] <= wr.data;
		end
		if (rd_en) begin
			case (rd_reg)
				// vl and masks come from the live control regs
				vmm_pkg::REG_VL: rd_data <= ctrl.vl;
				vmm_pkg::REG_A_ROWS: rd_data <= mask_word(ctrl.a_rows);
				vmm_pkg::REG_A_COLS: rd_data <= mask_word(ctrl.a_cols);
				vmm_pkg::REG_B_COLS: rd_data <= mask_word(ctrl.b_cols);
				default: rd_data <= mem[rd_reg];
			endcase
		end
	end

	// vl and the three masks as separate registers
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ctrl.vl <= '0;
			ctrl.a_rows <= '1;
			ctrl.a_cols <= '1;
			ctrl.b_cols <= '1;
		end else if (wr.en) begin
			case (wr.idx)
				vmm_pkg::REG_VL: ctrl.vl <= wr.data;
				// a_rows, picks accumulating lanes
				vmm_pkg::REG_A_ROWS: ctrl.a_rows <= wr.data.mask_field.mask;
				// a_cols / b_rows, kept for the register map only
				vmm_pkg::REG_A_COLS: ctrl.a_cols <= wr.data.mask_field.mask;
				// b_cols, picks lanes summed into result
				vmm_pkg::REG_B_COLS: ctrl.b_cols <= wr.data.mask_field.mask;
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/wb_slave_port.sv
// wishbone classic slave port
`timescale 1ns/1ps
`default_nettype none

module wb_slave_port (
	input wire logic clk,
	input wire logic resetn,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [vmm_pkg::ADR_WIDTH-1:0] adr,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] dat_w,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] reg_rd_data,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] result,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] status,
	output logic ack,
	output logic [vmm_pkg::DATA_WIDTH-1:0] dat_r,
	output vmm_pkg::regfile_wr_s reg_wr,
	output logic reg_rd_en,
	output logic [vmm_pkg::LOG2_NUM_REGS-1:0] reg_rd_reg,
	output logic a_we,
	output logic b_we,
	output vmm_pkg::vmm_word_u op_word,
	output logic vl_load
);

	logic take;
	logic eng_sel;
	logic [1:0] eng_off;
	logic wr_en_q;
	logic [vmm_pkg::LOG2_NUM_REGS-1:0] idx_q;
	vmm_pkg::vmm_word_u data_q;
	logic rd_eng_q;
	logic [1:0] rd_off_q;

	// new request, blocked in the ack cycle so ack stays one clock
	assign take = cyc & stb & ~ack;
	// adr[5] picks the engine space
	assign eng_sel = adr[vmm_pkg::ADR_WIDTH-1];
	assign eng_off = adr[1:0];

	// read goes out now, data lands with ack
	assign reg_rd_en = take & ~we & ~eng_sel;
	assign reg_rd_reg = adr[vmm_pkg::LOG2_NUM_REGS-1:0];

	// ack and one-cycle strobes
	always_ff @(posedge clk) begin
		if (!resetn) begin
			ack <= 1'b0;
			wr_en_q <= 1'b0;
			a_we <= 1'b0;
			b_we <= 1'b0;
			vl_load <= 1'b0;
		end else begin
			ack <= take;
			wr_en_q <= take & we & ~eng_sel;
			a_we <= take & we & eng_sel & (eng_off == vmm_pkg::ENG_A);
			b_we <= take & we & eng_sel & (eng_off == vmm_pkg::ENG_B);
			vl_load <= take & we & ~eng_sel &
				(adr[vmm_pkg::LOG2_NUM_REGS-1:0] == vmm_pkg::REG_VL);
		end
	end

	// captured address and data
	always_ff @(posedge clk) begin
		if (take) begin
			data_q <= dat_w;
			idx_q <= adr[vmm_pkg::LOG2_NUM_REGS-1:0];
			rd_eng_q <= eng_sel;
			rd_off_q <= eng_off;
		end
	end

	assign reg_wr = '{en: wr_en_q, idx: idx_q, data: data_q};
	// same word feeds the operand path
	assign op_word = data_q;

	// read mux, valid while ack is high
	always_comb begin
		if (!rd_eng_q) begin
			dat_r = reg_rd_data;
		end else begin
			case (rd_off_q)
				vmm_pkg::ENG_RESULT: dat_r = result;
				vmm_pkg::ENG_STATUS: dat_r = status;
				// operand slots are write only
				default: dat_r = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verification/vmm_asserts.sv
// wishbone and reset assertions
`timescale 1ns/1ps
`default_nettype none

module vmm_asserts (
	input wire logic clk,
	input wire logic resetn,
	input wire logic cyc,
	input wire logic stb,
	input wire logic ack,
	input wire vmm_pkg::ctrl_regs_s ctrl,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] result,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] status
);

	int fail_count = 0;

	// new strobe, ack on the next clock
	ack_after_strobe: assert property (@(posedge clk) disable iff (!resetn)
		cyc && stb && !ack |=> ack)
		else begin
			$error("ack did not follow a strobe by one cycle");
			fail_count++;
		end

	// single-cycle ack
	ack_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
		ack |=> !ack)
		else begin
			$error("ack stayed high for two cycles");
			fail_count++;
		end

	ack_low_in_reset: assert property (@(posedge clk) !resetn |=> !ack)
		else begin
			$error("ack high while in reset");
			fail_count++;
		end

	// vl zero, masks open, nothing accumulated
	reset_values: assert property (@(posedge clk) !resetn |=>
		ctrl.vl == '0 && ctrl.a_rows == '1 && ctrl.a_cols == '1 &&
		ctrl.b_cols == '1 && result == '0 && !status[0])
		else begin
			$error("control or result state wrong after reset");
			fail_count++;
		end

endmodule

`default_nettype wire

//--- verification/vmm_checker.sv
// bus read checker
`timescale 1ns/1ps
`default_nettype none

module vmm_checker (
	input wire logic clk,
	input wire logic resetn,
	input wire logic cyc,
	input wire logic stb,
	input wire logic we,
	input wire logic [vmm_pkg::DATA_WIDTH-1:0] dat_r,
	input wire logic ack,
	output logic poll_busy
);

	// status reads before a poll is given up
	localparam int POLL_LIMIT = 16;
	localparam int MODE_VALUE = 1;
	localparam int MODE_POLL = 2;

	// expectation, set by the testbench before each read
	int mode = 0;
	int arm_id = 0;
	string test_name = "";
	logic [vmm_pkg::DATA_WIDTH-1:0] expected = '0;
	// checker state
	int done_id = 0;
	int polls = 0;
	logic rd_pending;
	int mismatch_count = 0;
	int stuck_count = 0;

	assign poll_busy = (mode == MODE_POLL) && (done_id != arm_id);

	task automatic expect_value(input string name, input logic [31:0] val);
		test_name = name;
		expected = val;
		mode = MODE_VALUE;
		arm_id++;
	endtask

	// keep reading status until done is seen
	task automatic expect_poll(input string name, input logic [31:0] val);
		test_name = name;
		expected = val;
		mode = MODE_POLL;
		arm_id++;
	endtask

	task automatic compare_word(input logic [31:0] actual);
		if (actual !== expected) begin
			$display("FAILED %s: expected %08h, actual %08h", test_name, expected, actual);
			mismatch_count++;
		end
	endtask

	always @(posedge clk) begin
		if (!resetn) begin
			rd_pending <= 1'b0;
		end else begin
			// read in flight from strobe to ack
			if (cyc && stb && !ack) begin
				rd_pending <= !we;
			end else if (ack) begin
				rd_pending <= 1'b0;
			end
			// dat_r is valid in the ack cycle
			if (ack && rd_pending && done_id != arm_id) begin
				if (mode == MODE_VALUE) begin
					compare_word(dat_r);
					done_id <= arm_id;
				end else if (dat_r[0]) begin
					compare_word(dat_r);
					done_id <= arm_id;
					polls <= 0;
				end else if (polls + 1 >= POLL_LIMIT) begin
					$display("%s: done never came after %0d status reads",
						test_name, POLL_LIMIT);
					stuck_count++;
					done_id <= arm_id;
					polls <= 0;
				end else begin
					polls <= polls + 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- verification/vmm_tb.sv
// vector matmul testbench
`timescale 1ns/1ps
`default_nettype none

module vmm_tb;

	logic clk;
	logic resetn;
	logic cyc;
	logic stb;
	logic we;
	logic [vmm_pkg::ADR_WIDTH-1:0] adr;
	logic [vmm_pkg::DATA_WIDTH-1:0] dat_w;
	logic [vmm_pkg::DATA_WIDTH-1:0] dat_r;
	logic ack;
	logic poll_busy;
	// one entry per trace line
	string ops[$];
	string names[$];
	logic [31:0] adrs[$];
	logic [31:0] datas[$];
	logic [31:0] exps[$];
	int bad_lines = 0;
	int cycles = 0;
	int cycle_limit = 100000;
	int total;

	vmm_top vmm_top_i (
		.clk(clk),
		.resetn(resetn),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.adr(adr),
		.dat_w(dat_w),
		.dat_r(dat_r),
		.ack(ack)
	);

	vmm_checker checker_i (
		.clk(clk),
		.resetn(resetn),
		.cyc(cyc),
		.stb(stb),
		.we(we),
		.dat_r(dat_r),
		.ack(ack),
		.poll_busy(poll_busy)
	);

	bind vmm_top vmm_asserts vmm_asserts_i (
		.clk(clk),
		.resetn(resetn),
		.cyc(cyc),
		.stb(stb),
		.ack(ack),
		.ctrl(ctrl),
		.result(result),
		.status(status)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// hung run guard
	initial begin
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

	task automatic load_trace();
		int fd;
		int n;
		string line;
		string op;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] e;
		fd = $fopen("verification/vmm_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open verification/vmm_trace.txt");
			bad_lines++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				// skip comments and blank lines
				if (line.len() < 2 || line[0] == "#") begin
					continue;
				end
				n = $sscanf(line, "%s %h %h %h %s", op, a, d, e, name);
				if (n != 5) begin
					$display("trace line could not be parsed: %s", line);
					bad_lines++;
					continue;
				end
				ops.push_back(op);
				adrs.push_back(a);
				datas.push_back(d);
				exps.push_back(e);
				names.push_back(name);
			end
			$fclose(fd);
		end
	endtask

	// one classic cycle, starts and ends on a falling edge
	task automatic bus_access(input logic write, input logic [31:0] a, input logic [31:0] d);
		cyc = 1'b1;
		stb = 1'b1;
		we = write;
		adr = a[vmm_pkg::ADR_WIDTH-1:0];
		dat_w = d;
		@(negedge clk);
		while (!ack) begin
			@(negedge clk);
		end
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		@(negedge clk);
	endtask

	task automatic run_line(input int i);
		if (ops[i] == "W") begin
			bus_access(1'b1, adrs[i], datas[i]);
		end else if (ops[i] == "R") begin
			checker_i.expect_value(names[i], exps[i]);
			bus_access(1'b0, adrs[i], '0);
		end else if (ops[i] == "P") begin
			checker_i.expect_poll(names[i], exps[i]);
			// status reads until the checker has seen done
			do begin
				bus_access(1'b0, adrs[i], '0);
			end while (poll_busy);
		end else begin
			$display("unknown trace operation %s in %s", ops[i], names[i]);
			bad_lines++;
		end
	endtask

	initial begin
		resetn = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		dat_w = '0;
		load_trace();
		cycle_limit = 40 * ops.size() + 100;
		repeat (5) @(negedge clk);
		resetn = 1'b1;
		@(negedge clk);
		for (int i = 0; i < ops.size(); i++) begin
			run_line(i);
		end
		repeat (2) @(negedge clk);
		total = checker_i.mismatch_count + checker_i.stuck_count +
			vmm_top_i.vmm_asserts_i.fail_count + bad_lines;
		$display("errors: %0d mismatch, %0d stuck poll, %0d assertion, %0d trace",
			checker_i.mismatch_count, checker_i.stuck_count,
			vmm_top_i.vmm_asserts_i.fail_count, bad_lines);
		if (total == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/vmm_trace.txt
# op adr data expect name, all hex; W write, R read and compare,
# P read status at adr until done is set, then compare the status word
R 00 00000000 00000000 reset_vl
R 1d 00000000 0000000f reset_b_cols
R 1e 00000000 0000000f reset_a_cols
R 1f 00000000 0000000f reset_a_rows
W 05 deadbeef 00000000 store_r5
R 05 00000000 deadbeef store_r5
W 1c 12345678 00000000 store_r28
R 1c 00000000 12345678 store_r28
W 01 a5a5a5a5 00000000 store_r1
R 01 00000000 a5a5a5a5 store_r1
W 1f fffffff5 00000000 store_a_rows
R 1f 00000000 00000005 store_a_rows
W 1e 00000003 00000000 store_a_cols
R 1e 00000000 00000003 store_a_cols
W 1f 0000000f 00000000 open_a_rows
W 00 00000003 00000000 dot_vl
R 00 00000000 00000003 dot_vl
W 20 04030201 00000000 dot_a0
W 21 01010101 00000000 dot_b0
W 20 fe02ff05 00000000 dot_a1
W 21 03020403 00000000 dot_b1
W 20 10101010 00000000 dot_a2
W 21 02010302 00000000 dot_b2
P 23 00000000 00000301 dot_status
R 22 00000000 00000093 dot_result
W 1f 00000005 00000000 mask_a_rows
W 1d 00000006 00000000 mask_b_cols
W 00 00000002 00000000 mask_vl
W 20 0708f9fd 00000000 mask_a0
W 21 02f60503 00000000 mask_b0
W 20 01fb0a02 00000000 mask_a1
W 21 050309fc 00000000 mask_b1
P 23 00000000 00000201 mask_status
R 22 00000000 ffffffa1 mask_result
W 1d 0000000f 00000000 mask_b_open
R 22 00000000 ffffff90 mask_a_rows_only
W 1f 0000000f 00000000 limit_open
W 20 7f7f7f7f 00000000 limit_extra_a
W 21 7f7f7f7f 00000000 limit_extra_b
R 22 00000000 ffffff90 limit_result
R 23 00000000 00000201 limit_status
W 00 00000002 00000000 reload_vl
R 22 00000000 00000000 reload_result
R 23 00000000 00000000 reload_status
W 20 7f7f7f7f 00000000 fresh_a0
W 21 7f7f7f7f 00000000 fresh_b0
W 20 80808080 00000000 fresh_a1
W 21 01010101 00000000 fresh_b1
P 23 00000000 00000201 fresh_status
W 20 01010101 00000000 fresh_extra_a
W 21 01010101 00000000 fresh_extra_b
R 22 00000000 0000fa04 fresh_result
R 23 00000000 00000201 fresh_status_after

//--- vmatmul.f
source/vmm_pkg.sv
source/vregfile_control.sv
source/wb_slave_port.sv
source/operand_feeder.sv
source/mac_lane.sv
source/result_collector.sv
source/vmm_top.sv
verification/vmm_asserts.sv
verification/vmm_checker.sv
verification/vmm_tb.sv
